// ==== vdecode_pkg.sv ====
package vdecode_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int INSTR_W    = 32;

  // major opcodes; only VECTOR is decoded, the fp load/store codes are named for reference
  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  // funct3 category of a VECTOR word
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // funct6 of the integer OPI group
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // funct6 of the OPM group, reductions and mul/div only
  typedef enum logic [5:0] {
    VREDSUM  = 6'b000000,
    VREDAND  = 6'b000001,
    VREDOR   = 6'b000010,
    VREDXOR  = 6'b000011,
    VREDMINU = 6'b000100,
    VREDMIN  = 6'b000101,
    VREDMAXU = 6'b000110,
    VREDMAX  = 6'b000111,
    VDIVU    = 6'b100000,
    VDIV     = 6'b100001,
    VREMU    = 6'b100010,
    VREM     = 6'b100011,
    VMULHU   = 6'b100100,
    VMUL     = 6'b100101,
    VMULHSU  = 6'b100110,
    VMULH    = 6'b100111
  } vopm_t;

  // BAD_OP sits at zero so a cleared register reads as no operation
  typedef enum logic [5:0] {
    BAD_OP,
    OP_VADD, OP_VSUB, OP_VRSUB,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM
  } vop_t;

  typedef enum logic [1:0] {ARITH, RED, MUL, DIV} fu_type_t;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB,
    VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA,
    VALU_COMP, VALU_MM
  } valu_op_t;

  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } comp_type_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

  // where operand 1 comes from
  typedef enum logic [1:0] {SRC_V, SRC_X, SRC_I} operand_src_t;

endpackage

// ==== vop_decode.sv ====
`timescale 1ns/1ps

module vop_decode (
  input  logic [vdecode_pkg::INSTR_W-1:0]    instr,
  output vdecode_pkg::vop_t                  op,
  output logic                               illegal_insn,
  output vdecode_pkg::vfunct3_t              category,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vd,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs1,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs2,
  output logic                               vm
);
  import vdecode_pkg::*;

  opcode_t  opcode;
  vfunct3_t funct3;
  vopi_t    funct6_opi;
  vopm_t    funct6_opm;
  logic     is_vopi;
  logic     is_vopm;
  // restricted funct3 forms
  logic     form_vvx;
  logic     form_vxi;
  logic     form_mvv;

  assign opcode     = opcode_t'(instr[6:0]);
  assign funct3     = vfunct3_t'(instr[14:12]);
  assign funct6_opi = vopi_t'(instr[31:26]);
  assign funct6_opm = vopm_t'(instr[31:26]);

  assign vd       = instr[11:7];
  assign vs1      = instr[19:15];
  assign vs2      = instr[24:20];
  assign vm       = instr[25];
  assign category = funct3;

  // config and float categories fall through both groups
  assign is_vopi = (opcode == VECTOR) && (funct3 inside {OPIVV, OPIVX, OPIVI});
  assign is_vopm = (opcode == VECTOR) && (funct3 inside {OPMVV, OPMVX});

  assign form_vvx = (funct3 == OPIVV) || (funct3 == OPIVX);
  assign form_vxi = (funct3 == OPIVX) || (funct3 == OPIVI);
  assign form_mvv = (funct3 == OPMVV);

  always_comb begin
    op = BAD_OP;
    if (is_vopi) begin
      case (funct6_opi)
        // all three forms
        VADD:    op = OP_VADD;
        VAND:    op = OP_VAND;
        VOR:     op = OP_VOR;
        VXOR:    op = OP_VXOR;
        VSLL:    op = OP_VSLL;
        VSRL:    op = OP_VSRL;
        VSRA:    op = OP_VSRA;
        VMSEQ:   op = OP_VMSEQ;
        VMSNE:   op = OP_VMSNE;
        VMSLEU:  op = OP_VMSLEU;
        VMSLE:   op = OP_VMSLE;
        // no immediate form
        VSUB:    op = form_vvx ? OP_VSUB : BAD_OP;
        VMINU:   op = form_vvx ? OP_VMINU : BAD_OP;
        VMIN:    op = form_vvx ? OP_VMIN : BAD_OP;
        VMAXU:   op = form_vvx ? OP_VMAXU : BAD_OP;
        VMAX:    op = form_vvx ? OP_VMAX : BAD_OP;
        VMSLTU:  op = form_vvx ? OP_VMSLTU : BAD_OP;
        VMSLT:   op = form_vvx ? OP_VMSLT : BAD_OP;
        // no vector-vector form
        VRSUB:   op = form_vxi ? OP_VRSUB : BAD_OP;
        VMSGTU:  op = form_vxi ? OP_VMSGTU : BAD_OP;
        VMSGT:   op = form_vxi ? OP_VMSGT : BAD_OP;
        default: op = BAD_OP;
      endcase
    end else if (is_vopm) begin
      case (funct6_opm)
        // reductions are vector-vector only
        VREDSUM:  op = form_mvv ? OP_VREDSUM : BAD_OP;
        VREDAND:  op = form_mvv ? OP_VREDAND : BAD_OP;
        VREDOR:   op = form_mvv ? OP_VREDOR : BAD_OP;
        VREDXOR:  op = form_mvv ? OP_VREDXOR : BAD_OP;
        VREDMINU: op = form_mvv ? OP_VREDMINU : BAD_OP;
        VREDMIN:  op = form_mvv ? OP_VREDMIN : BAD_OP;
        VREDMAXU: op = form_mvv ? OP_VREDMAXU : BAD_OP;
        VREDMAX:  op = form_mvv ? OP_VREDMAX : BAD_OP;
        // mul/div accept both OPM forms
        VMUL:     op = OP_VMUL;
        VMULH:    op = OP_VMULH;
        VMULHU:   op = OP_VMULHU;
        VMULHSU:  op = OP_VMULHSU;
        VDIVU:    op = OP_VDIVU;
        VDIV:     op = OP_VDIV;
        VREMU:    op = OP_VREMU;
        VREM:     op = OP_VREM;
        default:  op = BAD_OP;
      endcase
    end
  end

  assign illegal_insn = (op == BAD_OP);

endmodule

// ==== vunit_ctrl.sv ====
`timescale 1ns/1ps

module vunit_ctrl (
  input  vdecode_pkg::vop_t       op,
  output vdecode_pkg::fu_type_t   fu_type,
  output vdecode_pkg::valu_op_t   aluop,
  output vdecode_pkg::comp_type_t comp_type,
  output vdecode_pkg::minmax_t    minmax_type,
  output logic                    is_signed,
  output logic                    single_bit_op,
  output logic                    vd_zero,
  output logic                    high_low,
  output logic                    div_quot
);
  import vdecode_pkg::*;

  // unit select
  always_comb begin
    case (op)
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: fu_type = RED;
      OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:         fu_type = MUL;
      OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:             fu_type = DIV;
      default:                                          fu_type = ARITH;
    endcase
  end

  always_comb begin
    case (op)
      OP_VSUB, OP_VRSUB:      aluop = VALU_SUB;
      OP_VAND, OP_VREDAND:    aluop = VALU_AND;
      OP_VOR, OP_VREDOR:      aluop = VALU_OR;
      OP_VXOR, OP_VREDXOR:    aluop = VALU_XOR;
      OP_VSLL:                aluop = VALU_SLL;
      OP_VSRL:                aluop = VALU_SRL;
      OP_VSRA:                aluop = VALU_SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: aluop = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: aluop = VALU_MM;
      // add, redsum, and the mul/div ops that never use the alu
      default:                aluop = VALU_ADD;
    endcase
  end

  always_comb begin
    case (op)
      OP_VMSNE:  comp_type = VSNE;
      OP_VMSLTU: comp_type = VSLTU;
      OP_VMSLT:  comp_type = VSLT;
      OP_VMSLEU: comp_type = VSLEU;
      OP_VMSLE:  comp_type = VSLE;
      OP_VMSGTU: comp_type = VSGTU;
      OP_VMSGT:  comp_type = VSGT;
      default:   comp_type = VSEQ;
    endcase
  end

  always_comb begin
    case (op)
      OP_VMINU, OP_VREDMINU: minmax_type = MINU;
      OP_VMAX, OP_VREDMAX:   minmax_type = MAX;
      OP_VMAXU, OP_VREDMAXU: minmax_type = MAXU;
      default:               minmax_type = MIN;
    endcase
  end

  // eq/ne count as signed, same result either way
  always_comb begin
    case (op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX,
      OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLE, OP_VMSGT,
      OP_VREDSUM, OP_VREDMIN, OP_VREDMAX,
      OP_VMUL, OP_VMULH, OP_VMULHSU, OP_VDIV, OP_VREM: is_signed = 1'b1;
      default:                                         is_signed = 1'b0;
    endcase
  end

  // compares write one mask bit per element
  assign single_bit_op = op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
                                    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT};

  // reductions write element 0 only
  assign vd_zero  = (fu_type == RED);
  assign high_low = op inside {OP_VMULH, OP_VMULHU, OP_VMULHSU};
  assign div_quot = op inside {OP_VDIVU, OP_VDIV};

endmodule

// ==== vdecode_stage.sv ====
`timescale 1ns/1ps

module vdecode_stage #(
  parameter int XLEN = 32
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               instr_valid,
  output logic                               instr_ready,
  input  logic                               ctrl_ready,
  output logic                               ctrl_valid,
  input  vdecode_pkg::vop_t                  dec_op,
  input  logic                               dec_illegal_insn,
  input  vdecode_pkg::vfunct3_t              dec_category,
  input  logic [vdecode_pkg::REG_ADDR_W-1:0] dec_vd,
  input  logic [vdecode_pkg::REG_ADDR_W-1:0] dec_vs1,
  input  logic [vdecode_pkg::REG_ADDR_W-1:0] dec_vs2,
  input  logic                               dec_vm,
  input  vdecode_pkg::fu_type_t              dec_fu_type,
  input  vdecode_pkg::valu_op_t              dec_aluop,
  input  vdecode_pkg::comp_type_t            dec_comp_type,
  input  vdecode_pkg::minmax_t               dec_minmax_type,
  input  logic                               dec_is_signed,
  input  logic                               dec_single_bit_op,
  input  logic                               dec_vd_zero,
  input  logic                               dec_high_low,
  input  logic                               dec_div_quot,
  output vdecode_pkg::vop_t                  op,
  output logic                               illegal_insn,
  output vdecode_pkg::vfunct3_t              category,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vd,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs1,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs2,
  output logic                               vm,
  output vdecode_pkg::fu_type_t              fu_type,
  output vdecode_pkg::valu_op_t              aluop,
  output vdecode_pkg::comp_type_t            comp_type,
  output vdecode_pkg::minmax_t               minmax_type,
  output logic                               is_signed,
  output logic                               single_bit_op,
  output logic                               vd_zero,
  output logic                               high_low,
  output logic                               div_quot,
  output vdecode_pkg::operand_src_t          rs1_type,
  output logic [XLEN-1:0]                    imm
);
  import vdecode_pkg::*;

  logic         load;
  logic         is_shift;
  operand_src_t rs1_src;
  logic [XLEN-1:0] imm_ext;

  // single entry that refills in the cycle it drains
  assign instr_ready = !ctrl_valid || ctrl_ready;
  assign load        = instr_valid && instr_ready;

  always_comb begin
    case (dec_category)
      OPIVI:        rs1_src = SRC_I;
      OPIVX, OPMVX: rs1_src = SRC_X;
      default:      rs1_src = SRC_V;
    endcase
  end

  // shift amounts zero-extend while other imm5 values sign-extend
  assign is_shift = dec_op inside {OP_VSLL, OP_VSRL, OP_VSRA};
  assign imm_ext  = is_shift ? {{(XLEN-REG_ADDR_W){1'b0}}, dec_vs1}
                             : {{(XLEN-REG_ADDR_W){dec_vs1[REG_ADDR_W-1]}}, dec_vs1};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_valid    <= 1'b0;
      op            <= BAD_OP;
      illegal_insn  <= 1'b0;
      category      <= OPIVV;
      vd            <= '0;
      vs1           <= '0;
      vs2           <= '0;
      vm            <= 1'b0;
      fu_type       <= ARITH;
      aluop         <= VALU_ADD;
      comp_type     <= VSEQ;
      minmax_type   <= MIN;
      is_signed     <= 1'b0;
      single_bit_op <= 1'b0;
      vd_zero       <= 1'b0;
      high_low      <= 1'b0;
      div_quot      <= 1'b0;
      rs1_type      <= SRC_V;
      imm           <= '0;
    end else begin
      if (instr_ready) begin
        ctrl_valid <= instr_valid;
      end
      if (load) begin
        op            <= dec_op;
        illegal_insn  <= dec_illegal_insn;
        category      <= dec_category;
        vd            <= dec_vd;
        vs1           <= dec_vs1;
        vs2           <= dec_vs2;
        vm            <= dec_vm;
        fu_type       <= dec_fu_type;
        aluop         <= dec_aluop;
        comp_type     <= dec_comp_type;
        minmax_type   <= dec_minmax_type;
        is_signed     <= dec_is_signed;
        single_bit_op <= dec_single_bit_op;
        vd_zero       <= dec_vd_zero;
        high_low      <= dec_high_low;
        div_quot      <= dec_div_quot;
        rs1_type      <= rs1_src;
        imm           <= imm_ext;
      end
    end
  end

  // a stalled result must not change under the sink
  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && !ctrl_ready |=> ctrl_valid && $stable({op, illegal_insn, category,
      vd, vs1, vs2, vm, fu_type, aluop, comp_type, minmax_type, is_signed,
      single_bit_op, vd_zero, high_low, div_quot, rs1_type, imm}));

  // decoder and register agree on what an illegal word looks like
  a_bad_op_flagged: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && (op == BAD_OP) |-> illegal_insn);

endmodule

// ==== vector_control_unit.sv ====
`timescale 1ns/1ps

module vector_control_unit #(
  parameter int XLEN = 32
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [vdecode_pkg::INSTR_W-1:0]    instr,
  input  logic                               instr_valid,
  output logic                               instr_ready,
  input  logic                               ctrl_ready,
  output logic                               ctrl_valid,
  output vdecode_pkg::vop_t                  op,
  output logic                               illegal_insn,
  output vdecode_pkg::vfunct3_t              category,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vd,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs1,
  output logic [vdecode_pkg::REG_ADDR_W-1:0] vs2,
  output logic                               vm,
  output vdecode_pkg::fu_type_t              fu_type,
  output vdecode_pkg::valu_op_t              aluop,
  output vdecode_pkg::comp_type_t            comp_type,
  output vdecode_pkg::minmax_t               minmax_type,
  output logic                               is_signed,
  output logic                               single_bit_op,
  output logic                               vd_zero,
  output logic                               high_low,
  output logic                               div_quot,
  output vdecode_pkg::operand_src_t          rs1_type,
  output logic [XLEN-1:0]                    imm
);
  import vdecode_pkg::*;

  // combinational decode of the word on the input
  vop_t                  dec_op;
  logic                  dec_illegal_insn;
  vfunct3_t              dec_category;
  logic [REG_ADDR_W-1:0] dec_vd;
  logic [REG_ADDR_W-1:0] dec_vs1;
  logic [REG_ADDR_W-1:0] dec_vs2;
  logic                  dec_vm;
  fu_type_t              dec_fu_type;
  valu_op_t              dec_aluop;
  comp_type_t            dec_comp_type;
  minmax_t               dec_minmax_type;
  logic                  dec_is_signed;
  logic                  dec_single_bit_op;
  logic                  dec_vd_zero;
  logic                  dec_high_low;
  logic                  dec_div_quot;

  vop_decode u_decode (
    .instr        (instr),
    .op           (dec_op),
    .illegal_insn (dec_illegal_insn),
    .category     (dec_category),
    .vd           (dec_vd),
    .vs1          (dec_vs1),
    .vs2          (dec_vs2),
    .vm           (dec_vm)
  );

  vunit_ctrl u_ctrl (
    .op            (dec_op),
    .fu_type       (dec_fu_type),
    .aluop         (dec_aluop),
    .comp_type     (dec_comp_type),
    .minmax_type   (dec_minmax_type),
    .is_signed     (dec_is_signed),
    .single_bit_op (dec_single_bit_op),
    .vd_zero       (dec_vd_zero),
    .high_low      (dec_high_low),
    .div_quot      (dec_div_quot)
  );

  vdecode_stage #(
    .XLEN (XLEN)
  ) u_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid       (instr_valid),
    .instr_ready       (instr_ready),
    .ctrl_ready        (ctrl_ready),
    .ctrl_valid        (ctrl_valid),
    .dec_op            (dec_op),
    .dec_illegal_insn  (dec_illegal_insn),
    .dec_category      (dec_category),
    .dec_vd            (dec_vd),
    .dec_vs1           (dec_vs1),
    .dec_vs2           (dec_vs2),
    .dec_vm            (dec_vm),
    .dec_fu_type       (dec_fu_type),
    .dec_aluop         (dec_aluop),
    .dec_comp_type     (dec_comp_type),
    .dec_minmax_type   (dec_minmax_type),
    .dec_is_signed     (dec_is_signed),
    .dec_single_bit_op (dec_single_bit_op),
    .dec_vd_zero       (dec_vd_zero),
    .dec_high_low      (dec_high_low),
    .dec_div_quot      (dec_div_quot),
    .op                (op),
    .illegal_insn      (illegal_insn),
    .category          (category),
    .vd                (vd),
    .vs1               (vs1),
    .vs2               (vs2),
    .vm                (vm),
    .fu_type           (fu_type),
    .aluop             (aluop),
    .comp_type         (comp_type),
    .minmax_type       (minmax_type),
    .is_signed         (is_signed),
    .single_bit_op     (single_bit_op),
    .vd_zero           (vd_zero),
    .high_low          (high_low),
    .div_quot          (div_quot),
    .rs1_type          (rs1_type),
    .imm               (imm)
  );

endmodule

// ==== tb_vector_control_unit.sv ====
`timescale 1ns/1ps

module tb_vector_control_unit;

  localparam int XLEN      = 32;
  // instr, op, illegal, fu, alu, cmp, minmax, signed, bit, vd_zero, high_low, div_quot, src, imm
  localparam int COLS      = 14;
  localparam int MAX_LINES = 64;
  localparam int WAIT_MAX  = 200;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [31:0]     instr;
  logic            instr_valid;
  logic            instr_ready;
  logic            ctrl_ready;
  logic            ctrl_valid;
  logic [5:0]      op;
  logic            illegal_insn;
  logic [2:0]      category;
  logic [4:0]      vd;
  logic [4:0]      vs1;
  logic [4:0]      vs2;
  logic            vm;
  logic [1:0]      fu_type;
  logic [3:0]      aluop;
  logic [2:0]      comp_type;
  logic [1:0]      minmax_type;
  logic            is_signed;
  logic            single_bit_op;
  logic            vd_zero;
  logic            high_low;
  logic            div_quot;
  logic [1:0]      rs1_type;
  logic [XLEN-1:0] imm;

  // word 0 holds the line count and COLS words follow per line
  logic [31:0] trace_mem [0:COLS*MAX_LINES];
  int          num_lines;
  int          drive_idx;
  int          run_errors = 0;
  logic        timed_out;

  // owned by the output monitor
  int          value_errors = 0;
  int          other_errors = 0;
  int          consumed = 0;
  int          exp_queue[$];
  logic        stalled = 1'b0;
  logic        rst_prev = 1'b0;
  logic [75:0] out_held = '0;
  logic [75:0] out_now;

  vector_control_unit #(
    .XLEN (XLEN)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr         (instr),
    .instr_valid   (instr_valid),
    .instr_ready   (instr_ready),
    .ctrl_ready    (ctrl_ready),
    .ctrl_valid    (ctrl_valid),
    .op            (op),
    .illegal_insn  (illegal_insn),
    .category      (category),
    .vd            (vd),
    .vs1           (vs1),
    .vs2           (vs2),
    .vm            (vm),
    .fu_type       (fu_type),
    .aluop         (aluop),
    .comp_type     (comp_type),
    .minmax_type   (minmax_type),
    .is_signed     (is_signed),
    .single_bit_op (single_bit_op),
    .vd_zero       (vd_zero),
    .high_low      (high_low),
    .div_quot      (div_quot),
    .rs1_type      (rs1_type),
    .imm           (imm)
  );

  always #5 clk = ~clk;

  assign out_now = {op, illegal_insn, category, vd, vs1, vs2, vm, fu_type, aluop,
                    comp_type, minmax_type, is_signed, single_bit_op, vd_zero,
                    high_low, div_quot, rs1_type, imm};

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, expected);
    end
  endtask

  // pops the oldest accepted line and checks the register against it
  task automatic check_result();
    int          base;
    logic [31:0] word;
    if (exp_queue.size() == 0) begin
      other_errors++;
      $display("result at %0t has no accepted instruction behind it", $time);
    end else begin
      base = 1 + exp_queue.pop_front() * COLS;
      word = trace_mem[base];
      consumed++;
      compare_field("illegal_insn", 32'(illegal_insn), trace_mem[base+2]);
      // illegal lines carry no control values
      if (trace_mem[base+2] == 32'd0) begin
        compare_field("op", 32'(op), trace_mem[base+1]);
        compare_field("category", 32'(category), 32'(word[14:12]));
        compare_field("vd", 32'(vd), 32'(word[11:7]));
        compare_field("vs1", 32'(vs1), 32'(word[19:15]));
        compare_field("vs2", 32'(vs2), 32'(word[24:20]));
        compare_field("vm", 32'(vm), 32'(word[25]));
        compare_field("fu_type", 32'(fu_type), trace_mem[base+3]);
        compare_field("aluop", 32'(aluop), trace_mem[base+4]);
        compare_field("comp_type", 32'(comp_type), trace_mem[base+5]);
        compare_field("minmax_type", 32'(minmax_type), trace_mem[base+6]);
        compare_field("is_signed", 32'(is_signed), trace_mem[base+7]);
        compare_field("single_bit_op", 32'(single_bit_op), trace_mem[base+8]);
        compare_field("vd_zero", 32'(vd_zero), trace_mem[base+9]);
        compare_field("high_low", 32'(high_low), trace_mem[base+10]);
        compare_field("div_quot", 32'(div_quot), trace_mem[base+11]);
        compare_field("rs1_type", 32'(rs1_type), trace_mem[base+12]);
        compare_field("imm", 32'(imm), trace_mem[base+13]);
      end
    end
  endtask

  // the handshake sampled here at mid-cycle completes on the next rising edge
  always @(negedge clk) begin
    if (!rst_n || !rst_prev) begin
      compare_field("ctrl_valid", 32'(ctrl_valid), 32'd0);
    end
    if (rst_n) begin
      if (stalled && !ctrl_valid) begin
        other_errors++;
        $display("ctrl_valid dropped at %0t while the sink was stalling", $time);
      end else if (stalled && out_now !== out_held) begin
        value_errors++;
        $display("FAILED t=%0t stalled outputs: got %h, expected %h",
                 $time, out_now, out_held);
      end
      stalled  = ctrl_valid && !ctrl_ready;
      out_held = out_now;
      if (ctrl_valid && ctrl_ready) begin
        check_result();
      end
      if (instr_valid && instr_ready) begin
        exp_queue.push_back(drive_idx);
      end
    end
    rst_prev = rst_n;
  end

  // random back-pressure from the sink
  initial begin
    ctrl_ready = 1'b0;
    void'($urandom(32'h71532453));
    forever begin
      @(posedge clk);
      ctrl_ready <= ($urandom % 4) != 0;
    end
  end

  task automatic send_instr(input int idx);
    int waited;
    waited = 0;
    @(posedge clk);
    drive_idx = idx;
    instr       <= trace_mem[1 + idx*COLS];
    instr_valid <= 1'b1;
    @(negedge clk);
    while (!instr_ready && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (!instr_ready) begin
      run_errors++;
      timed_out = 1'b1;
      $display("timeout: line %0d not accepted within %0d cycles", idx, WAIT_MAX);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (consumed < num_lines && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (consumed < num_lines) begin
      run_errors++;
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d results came out", consumed, num_lines);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    drive_idx   = 0;
    timed_out   = 1'b0;
    $readmemh("decode_trace.txt", trace_mem);
    num_lines = int'(trace_mem[0]);
    if (num_lines < 1 || num_lines > MAX_LINES) begin
      run_errors++;
      $display("trace holds %0d lines, expected 1 to %0d", num_lines, MAX_LINES);
      num_lines = 0;
    end

    // a valid word offered during reset must not reach the output
    @(posedge clk);
    instr       <= trace_mem[1];
    instr_valid <= 1'b1;
    repeat (9) @(posedge clk);
    rst_n       <= 1'b1;
    instr_valid <= 1'b0;

    for (int i = 0; i < num_lines && !timed_out; i++) begin
      send_instr(i);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    if (!timed_out) begin
      wait_drain();
    end
    if (exp_queue.size() != 0) begin
      run_errors++;
      $display("%0d accepted lines never came out", exp_queue.size());
    end

    $display("errors: %0d value mismatches, %0d other failures, %0d of %0d results checked",
             value_errors, other_errors + run_errors, consumed, num_lines);
    if (value_errors == 0 && other_errors == 0 && run_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== decode_trace.txt ====
// instr op illegal fu_type aluop comp_type minmax is_signed single_bit vd_zero high_low div_quot rs1_type imm
// first word is the line count in hex; illegal lines are checked on the illegal flag only
24
00218257 01 0 0 0 0 0 1 0 0 0 0 0 00000003 // vadd.vv vd=4 vm=0
0222C0D7 01 0 0 0 0 0 1 0 0 0 0 1 00000005 // vadd.vx
022830D7 01 0 0 0 0 0 1 0 0 0 0 2 FFFFFFF0 // vadd.vi imm 10000
0A22C0D7 02 0 0 1 0 0 1 0 0 0 0 1 00000005 // vsub.vx
0E2830D7 03 0 0 1 0 0 1 0 0 0 0 2 FFFFFFF0 // vrsub.vi
122180D7 04 0 0 9 0 1 0 0 0 0 0 0 00000003 // vminu.vv
1622C0D7 05 0 0 9 0 0 1 0 0 0 0 1 00000005 // vmin.vx
1A2180D7 06 0 0 9 0 3 0 0 0 0 0 0 00000003 // vmaxu.vv
1E22C0D7 07 0 0 9 0 2 1 0 0 0 0 1 00000005 // vmax.vx
262830D7 08 0 0 2 0 0 0 0 0 0 0 2 FFFFFFF0 // vand.vi
2A2180D7 09 0 0 3 0 0 0 0 0 0 0 0 00000003 // vor.vv
2E22C0D7 0A 0 0 4 0 0 0 0 0 0 0 1 00000005 // vxor.vx
962830D7 0B 0 0 5 0 0 0 0 0 0 0 2 00000010 // vsll.vi zero-extended
A22180D7 0C 0 0 6 0 0 0 0 0 0 0 0 00000003 // vsrl.vv
A62830D7 0D 0 0 7 0 0 0 0 0 0 0 2 00000010 // vsra.vi zero-extended
622830D7 0E 0 0 8 0 0 1 1 0 0 0 2 FFFFFFF0 // vmseq.vi
662180D7 0F 0 0 8 1 0 1 1 0 0 0 0 00000003 // vmsne.vv
6A22C0D7 10 0 0 8 2 0 0 1 0 0 0 1 00000005 // vmsltu.vx
6E2180D7 11 0 0 8 3 0 1 1 0 0 0 0 00000003 // vmslt.vv
722830D7 12 0 0 8 4 0 0 1 0 0 0 2 FFFFFFF0 // vmsleu.vi
7A2830D7 14 0 0 8 6 0 0 1 0 0 0 2 FFFFFFF0 // vmsgtu.vi
7E22C0D7 15 0 0 8 7 0 1 1 0 0 0 1 00000005 // vmsgt.vx
0021A0D7 16 0 1 0 0 0 1 0 1 0 0 0 00000003 // vredsum.vs vm=0
1221A0D7 1A 0 1 9 0 1 0 0 1 0 0 0 00000003 // vredminu.vs
1E21A0D7 1D 0 1 9 0 2 1 0 1 0 0 0 00000003 // vredmax.vs
9E22E0D7 1F 0 2 0 0 0 1 0 0 1 0 1 00000005 // vmulh.vx
9221A0D7 20 0 2 0 0 0 0 0 0 1 0 0 00000003 // vmulhu.vv
8622E0D7 23 0 3 0 0 0 1 0 0 0 1 1 00000005 // vdiv.vx
8A21A0D7 24 0 3 0 0 0 0 0 0 0 0 0 00000003 // vremu.vv
0A2830D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // sub with OPIVI
0222E0D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // redsum with OPMVX
7E2180D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // gt with OPIVV
0221F0D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // OPCFG
022190D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // OPFVV float category
02218087 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // LOAD_FP opcode
062180D7 00 1 0 0 0 0 0 0 0 0 0 0 00000000 // unlisted OPI funct6

// ==== sim.f ====
vdecode_pkg.sv
vop_decode.sv
vunit_ctrl.sv
vdecode_stage.sv
vector_control_unit.sv
tb_vector_control_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_vector_control_unit \
  -Mdir obj_dir -f sim.f
sim_out=$(./obj_dir/Vtb_vector_control_unit)
echo "$sim_out"
if echo "$sim_out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
